// ==== Bender.yml ====
package:
  name: imuldiv

sources:
  - files:
      - muldiv_pkg.sv
      - muldiv_ctrl.sv
      - mul_dpath.sv
      - div_dpath.sv
      - sign_fixup.sv
      - imuldiv_top.sv
  - target: test
    files:
      - tb_muldiv.sv

// ==== compile.f ====
muldiv_pkg.sv
muldiv_ctrl.sv
mul_dpath.sv
div_dpath.sv
sign_fixup.sv
imuldiv_top.sv
tb_muldiv.sv

// ==== div_dpath.sv ====
//--------------------------------------------------------------------------
// restoring magnitude divider
// one quotient bit per step, unsigned quotient and remainder after 32 steps
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module div_dpath (
  input  logic              clk,
  input  logic              reset,
  input  logic              load,
  input  logic              step,
  input  muldiv_pkg::word_t mag_a,
  input  muldiv_pkg::word_t mag_b,
  output muldiv_pkg::word_t quotient,
  output muldiv_pkg::word_t remainder
);

  // partial remainder, one bit wider than an operand
  logic [32:0]       prem_q;
  // dividend bits leave at the top, quotient bits enter at the bottom
  muldiv_pkg::word_t quo_q;
  muldiv_pkg::word_t dvsr_q;

  logic [32:0] prem_shift;
  logic [33:0] diff;
  logic        fits;

  //--------------------------------------------------------------------------
  // one restoring step
  //--------------------------------------------------------------------------

  // bring down the next dividend bit
  assign prem_shift = {prem_q[31:0], quo_q[31]};

  // extra top bit acts as the borrow
  assign diff = {1'b0, prem_shift} - {2'b0, dvsr_q};

  // no borrow means the divisor goes in
  // a zero divisor always fits, so the quotient fills with ones
  assign fits = !diff[33];

  always_ff @(posedge clk) begin
    if (reset) begin
      prem_q <= '0;
      quo_q  <= '0;
    end else if (load) begin
      prem_q <= '0;
      quo_q  <= mag_a;
    end else if (step) begin
      // keep the difference or restore the shifted value
      prem_q <= fits ? diff[32:0] : prem_shift;
      quo_q  <= {quo_q[30:0], fits};
    end
  end

  // divisor only changes on load
  always_ff @(posedge clk) begin
    if (load) begin
      dvsr_q <= mag_b;
    end
  end

  //--------------------------------------------------------------------------
  // outputs
  //--------------------------------------------------------------------------

  assign quotient  = quo_q;
  // remainder never exceeds the divisor, top bit stays clear
  assign remainder = prem_q[31:0];

  // after every step the partial remainder is below 2 to the 32
  // and below a nonzero divisor
  assert property (@(posedge clk) disable iff (reset)
    step |=> (!prem_q[32] && ((dvsr_q == '0) || (prem_q < {1'b0, dvsr_q}))));

endmodule

// ==== imuldiv_top.sv ====
//--------------------------------------------------------------------------
// iterative integer multiply/divide unit
// control FSM with multiply, divide and sign correction datapaths
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imuldiv_top (
  input  logic                   clk,
  input  logic                   reset,

  // request channel
  input  muldiv_pkg::muldiv_fn_e req_fn,
  input  muldiv_pkg::word_t      req_a,
  input  muldiv_pkg::word_t      req_b,
  input  logic                   req_val,
  output logic                   req_rdy,

  // response channel
  output muldiv_pkg::dword_t     resp_result,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  logic                   load;
  logic                   mul_step;
  logic                   div_step;
  muldiv_pkg::muldiv_fn_e cur_fn;

  muldiv_pkg::word_t  mag_a;
  muldiv_pkg::word_t  mag_b;
  muldiv_pkg::dword_t product;
  muldiv_pkg::word_t  quotient;
  muldiv_pkg::word_t  remainder;

  // handshake, step count and function select
  muldiv_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .req_fn   (req_fn),
    .load     (load),
    .mul_step (mul_step),
    .div_step (div_step),
    .cur_fn   (cur_fn)
  );

  // operand magnitudes in, corrected result out
  sign_fixup u_sign (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .req_fn      (req_fn),
    .cur_fn      (cur_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .mag_a       (mag_a),
    .mag_b       (mag_b),
    .product     (product),
    .quotient    (quotient),
    .remainder   (remainder),
    .resp_result (resp_result)
  );

  mul_dpath u_mul (
    .clk     (clk),
    .reset   (reset),
    .load    (load),
    .step    (mul_step),
    .mag_a   (mag_a),
    .mag_b   (mag_b),
    .product (product)
  );

  div_dpath u_div (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .step      (div_step),
    .mag_a     (mag_a),
    .mag_b     (mag_b),
    .quotient  (quotient),
    .remainder (remainder)
  );

endmodule

// ==== mul_dpath.sv ====
//--------------------------------------------------------------------------
// shift-add magnitude multiplier
// one multiplier bit per step, unsigned 64-bit product after 32 steps
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module mul_dpath (
  input  logic               clk,
  input  logic               reset,
  input  logic               load,
  input  logic               step,
  input  muldiv_pkg::word_t  mag_a,
  input  muldiv_pkg::word_t  mag_b,
  output muldiv_pkg::dword_t product
);

  // multiplicand moves left one place per step
  muldiv_pkg::dword_t mcand_q;
  // multiplier moves right, low bit gates the add
  muldiv_pkg::word_t  mplier_q;
  // running sum of partial products
  muldiv_pkg::dword_t acc_q;

  muldiv_pkg::dword_t acc_add;

  // partial product for this step
  assign acc_add = mplier_q[0] ? (acc_q + mcand_q) : acc_q;

  //--------------------------------------------------------------------------
  // operand shift registers
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      // zero extend into the wide register
      mcand_q  <= {32'b0, mag_a};
      mplier_q <= mag_b;
    end else if (step) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  //--------------------------------------------------------------------------
  // accumulator
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_q <= '0;
    end else if (load) begin
      // fresh sum for each operation
      acc_q <= '0;
    end else if (step) begin
      acc_q <= acc_add;
    end
  end

  // product held until the next load
  assign product = acc_q;

endmodule

// ==== muldiv_ctrl.sv ====
//--------------------------------------------------------------------------
// multiply/divide control FSM
// runs the val/rdy handshakes, counts bit steps and picks the datapath
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module muldiv_ctrl (
  input  logic                   clk,
  input  logic                   reset,

  // request handshake
  input  logic                   req_val,
  output logic                   req_rdy,

  // response handshake
  output logic                   resp_val,
  input  logic                   resp_rdy,

  // function code of the incoming request
  input  muldiv_pkg::muldiv_fn_e req_fn,

  // datapath controls
  output logic                   load,
  output logic                   mul_step,
  output logic                   div_step,
  output muldiv_pkg::muldiv_fn_e cur_fn
);

  muldiv_pkg::ctrl_state_e state_q;
  muldiv_pkg::ctrl_state_e state_d;
  muldiv_pkg::count_t      count_q;
  muldiv_pkg::muldiv_fn_e  fn_q;

  logic req_go;
  logic resp_go;
  logic last_step;
  logic calc;

  //--------------------------------------------------------------------------
  // handshake decode
  //--------------------------------------------------------------------------

  // ready only while nothing is in flight
  assign req_rdy  = (state_q == muldiv_pkg::ST_IDLE);
  // result is presented for the whole DONE state
  assign resp_val = (state_q == muldiv_pkg::ST_DONE);

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // count runs 0..31 while in CALC
  assign calc      = (state_q == muldiv_pkg::ST_CALC);
  assign last_step = (count_q == muldiv_pkg::count_t'(muldiv_pkg::NUM_ITERS - 1));

  // operands are captured on the accepting edge
  assign load = req_go;

  // only the datapath for the held function moves
  assign mul_step = calc && (fn_q == muldiv_pkg::FN_MUL);
  assign div_step = calc && (fn_q != muldiv_pkg::FN_MUL);

  assign cur_fn = fn_q;

  //--------------------------------------------------------------------------
  // next state
  //--------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      muldiv_pkg::ST_IDLE: begin
        if (req_go) begin
          state_d = muldiv_pkg::ST_CALC;
        end
      end
      muldiv_pkg::ST_CALC: begin
        // 32nd step edge leaves CALC
        if (last_step) begin
          state_d = muldiv_pkg::ST_DONE;
        end
      end
      muldiv_pkg::ST_DONE: begin
        // wait here for as long as the consumer stalls
        if (resp_go) begin
          state_d = muldiv_pkg::ST_IDLE;
        end
      end
      default: begin
        state_d = muldiv_pkg::ST_IDLE;
      end
    endcase
  end

  //--------------------------------------------------------------------------
  // state, counter and held function
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= muldiv_pkg::ST_IDLE;
      count_q <= '0;
      fn_q    <= muldiv_pkg::FN_MUL;
    end else begin
      state_q <= state_d;
      if (req_go) begin
        count_q <= '0;
        fn_q    <= req_fn;
      end else if (calc) begin
        // wraps back to zero on the last step
        count_q <= count_q + 1'b1;
      end
    end
  end

  // the two channels never both offer a transfer
  assert property (@(posedge clk) disable iff (reset) !(req_rdy && resp_val));

  // load only comes from IDLE and always starts a calculation
  assert property (@(posedge clk) disable iff (reset)
    load |-> req_rdy ##1 (state_q == muldiv_pkg::ST_CALC));

  // a stalled response keeps DONE and its function code
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(cur_fn)));

endmodule

// ==== muldiv_pkg.sv ====
//--------------------------------------------------------------------------
// iterative multiply/divide unit shared types
// function codes, control states, datapath widths and iteration count
//--------------------------------------------------------------------------

package muldiv_pkg;

  //--------------------------------------------------------------------------
  // widths
  //--------------------------------------------------------------------------

  // one operand, or one half of a divide result
  typedef logic [31:0] word_t;

  // full response word or multiplier product
  typedef logic [63:0] dword_t;

  // bit step counter, wraps at 32
  typedef logic [4:0] count_t;

  // one bit per cycle, so one step per operand bit
  localparam int NUM_ITERS = 32;

  //--------------------------------------------------------------------------
  // encodings
  //--------------------------------------------------------------------------

  // operation selector carried with each request
  // 2'b11 is unused and behaves as a signed divide
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } muldiv_fn_e;

  // control FSM states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } ctrl_state_e;

endpackage

// ==== sign_fixup.sv ====
//--------------------------------------------------------------------------
// sign handling around the unsigned multiply and divide cores
// operand magnitudes in, signed result correction and selection out
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module sign_fixup (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   load,
  input  muldiv_pkg::muldiv_fn_e req_fn,
  input  muldiv_pkg::muldiv_fn_e cur_fn,
  input  muldiv_pkg::word_t      req_a,
  input  muldiv_pkg::word_t      req_b,
  output muldiv_pkg::word_t      mag_a,
  output muldiv_pkg::word_t      mag_b,
  input  muldiv_pkg::dword_t     product,
  input  muldiv_pkg::word_t      quotient,
  input  muldiv_pkg::word_t      remainder,
  output muldiv_pkg::dword_t     resp_result
);

  logic signed_op;
  logic neg_a;
  logic neg_b;

  // flags held for the whole operation
  logic sign_a_q;
  logic sign_b_q;
  logic div_zero_q;

  logic               diff_sign;
  muldiv_pkg::dword_t prod_fix;
  muldiv_pkg::word_t  quo_fix;
  muldiv_pkg::word_t  rem_fix;

  //--------------------------------------------------------------------------
  // operand side
  //--------------------------------------------------------------------------

  // only DIVU treats the top bit as magnitude
  assign signed_op = (req_fn != muldiv_pkg::FN_DIVU);
  assign neg_a     = signed_op && req_a[31];
  assign neg_b     = signed_op && req_b[31];

  // two's complement negate, most negative value maps onto itself
  assign mag_a = neg_a ? (~req_a + 1'b1) : req_a;
  assign mag_b = neg_b ? (~req_b + 1'b1) : req_b;

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a_q   <= 1'b0;
      sign_b_q   <= 1'b0;
      div_zero_q <= 1'b0;
    end else if (load) begin
      sign_a_q   <= neg_a;
      sign_b_q   <= neg_b;
      div_zero_q <= (req_b == '0);
    end
  end

  //--------------------------------------------------------------------------
  // result side
  //--------------------------------------------------------------------------

  assign diff_sign = sign_a_q ^ sign_b_q;

  // signed product
  assign prod_fix = diff_sign ? (~product + 1'b1) : product;

  // quotient truncates toward zero
  // divide by zero keeps the all ones pattern
  assign quo_fix = (diff_sign && !div_zero_q) ? (~quotient + 1'b1) : quotient;

  // remainder follows the dividend
  assign rem_fix = sign_a_q ? (~remainder + 1'b1) : remainder;

  // divide packs remainder high, quotient low
  assign resp_result = (cur_fn == muldiv_pkg::FN_MUL) ? prod_fix : {rem_fix, quo_fix};

endmodule

// ==== tb_muldiv.sv ====
//--------------------------------------------------------------------------
// directed testbench for the iterative multiply/divide unit
// checks results, handshake timing and back-pressure against a reference
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_muldiv;

  localparam int RESET_CYCLES = 8;
  localparam int MAX_STALL    = 20;
  localparam int BP_OPS       = 8;
  localparam int RANDOM_OPS   = 200;
  // directed ops are 9 mul, 7 signed div, 4 unsigned div, 5 corners
  localparam int NUM_OPS      = 9 + 7 + 4 + 5 + BP_OPS + RANDOM_OPS;
  localparam int CYCLE_LIMIT  =
    NUM_OPS * (muldiv_pkg::NUM_ITERS + MAX_STALL + 4) + RESET_CYCLES;

  logic                   clk;
  logic                   reset;
  muldiv_pkg::muldiv_fn_e req_fn;
  muldiv_pkg::word_t      req_a;
  muldiv_pkg::word_t      req_b;
  logic                   req_val;
  logic                   req_rdy;
  muldiv_pkg::dword_t     resp_result;
  logic                   resp_val;
  logic                   resp_rdy;

  integer      seed;
  int unsigned cycle_count;

  imuldiv_top UUT (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // 100 ns period
  always #50 clk = ~clk;

  //--------------------------------------------------------------------------
  // timeout
  //--------------------------------------------------------------------------

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("CHECKS FAILED");
      $fatal(1, "timeout, tests did not finish within %0d cycles", CYCLE_LIMIT);
    end
  end

  //--------------------------------------------------------------------------
  // reference model and helpers
  //--------------------------------------------------------------------------

  // expected response from the arithmetic rules
  function automatic muldiv_pkg::dword_t ref_result(input muldiv_pkg::muldiv_fn_e fn,
                                                    input muldiv_pkg::word_t a,
                                                    input muldiv_pkg::word_t b);
    longint            sa64;
    longint            sb64;
    int                sa;
    int                sb;
    muldiv_pkg::word_t q;
    muldiv_pkg::word_t r;
    sa64 = longint'($signed(a));
    sb64 = longint'($signed(b));
    sa   = $signed(a);
    sb   = $signed(b);
    if (fn == muldiv_pkg::FN_MUL) begin
      return sa64 * sb64;
    end
    if (b == '0) begin
      // divide by zero, all ones quotient and dividend as remainder
      q = '1;
      r = a;
    end else if (fn == muldiv_pkg::FN_DIVU) begin
      q = a / b;
      r = a % b;
    end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      // signed overflow
      q = a;
      r = '0;
    end else begin
      // truncates toward zero, remainder follows the dividend
      q = sa / sb;
      r = sa % sb;
    end
    return {r, q};
  endfunction

  task automatic check_val(input string name, input muldiv_pkg::dword_t expected,
                           input muldiv_pkg::dword_t actual);
    if (expected !== actual) begin
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // holds val until the accepting edge, then drops it
  task automatic send_req(input muldiv_pkg::muldiv_fn_e fn, input muldiv_pkg::word_t a,
                          input muldiv_pkg::word_t b);
    @(posedge clk);
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    req_val <= 1'b1;
    @(negedge clk);
    while (!req_rdy) begin
      @(negedge clk);
    end
    @(posedge clk);
    req_val <= 1'b0;
  endtask

  // called right after the accepting edge
  task automatic get_resp(input string name, input int stall,
                          output muldiv_pkg::dword_t result);
    int                 lat;
    muldiv_pkg::dword_t held;
    lat = 0;
    @(negedge clk);
    while (!resp_val) begin
      lat++;
      // busy, no new request may be taken
      check_val(name, 64'd0, req_rdy);
      @(negedge clk);
    end
    check_val(name, muldiv_pkg::NUM_ITERS, lat);
    held = resp_result;
    // consumer stalls, result must stay put
    repeat (stall) begin
      @(posedge clk);
      @(negedge clk);
      check_val(name, 64'd1, resp_val);
      check_val(name, 64'd0, req_rdy);
      check_val(name, held, resp_result);
    end
    @(posedge clk);
    resp_rdy <= 1'b1;
    @(negedge clk);
    check_val(name, 64'd1, resp_val);
    check_val(name, held, resp_result);
    // response transfer edge
    @(posedge clk);
    resp_rdy <= 1'b0;
    @(negedge clk);
    check_val(name, 64'd0, resp_val);
    check_val(name, 64'd1, req_rdy);
    result = held;
  endtask

  // one full operation checked against the reference
  task automatic run_op(input string name, input muldiv_pkg::muldiv_fn_e fn,
                        input muldiv_pkg::word_t a, input muldiv_pkg::word_t b,
                        input int stall);
    muldiv_pkg::dword_t result;
    send_req(fn, a, b);
    get_resp(name, stall, result);
    check_val(name, ref_result(fn, a, b), result);
  endtask

  function automatic muldiv_pkg::muldiv_fn_e random_fn();
    int unsigned pick;
    pick = $unsigned($random(seed)) % 3;
    case (pick)
      0: return muldiv_pkg::FN_MUL;
      1: return muldiv_pkg::FN_DIV;
      default: return muldiv_pkg::FN_DIVU;
    endcase
  endfunction

  //--------------------------------------------------------------------------
  // tests
  //--------------------------------------------------------------------------

  task automatic test_mul_signed();
    run_op("test_mul_signed", muldiv_pkg::FN_MUL, 32'd0, 32'd5, 0);
    run_op("test_mul_signed", muldiv_pkg::FN_MUL, 32'd1, 32'h1234_5678, 0);
    run_op("test_mul_signed", muldiv_pkg::FN_MUL, 32'hffff_ffff, 32'hffff_ffff, 0);
    run_op("test_mul_signed", muldiv_pkg::FN_MUL, 32'hffff_ffff, 32'd7, 0);
    run_op("test_mul_signed", muldiv_pkg::FN_MUL, 32'h8000_0000, 32'h8000_0000, 0);
    run_op("test_mul_signed", muldiv_pkg::FN_MUL, 32'h8000_0000, 32'h7fff_ffff, 0);
    run_op("test_mul_signed", muldiv_pkg::FN_MUL, 32'h7fff_ffff, 32'h7fff_ffff, 0);
    run_op("test_mul_signed", muldiv_pkg::FN_MUL, -32'sd12345, 32'd678, 0);
    run_op("test_mul_signed", muldiv_pkg::FN_MUL, 32'd4321, -32'sd9876, 0);
  endtask

  task automatic test_div_signed();
    run_op("test_div_signed", muldiv_pkg::FN_DIV, 32'd100, 32'd7, 0);
    run_op("test_div_signed", muldiv_pkg::FN_DIV, -32'sd100, 32'd7, 0);
    run_op("test_div_signed", muldiv_pkg::FN_DIV, 32'd100, -32'sd7, 0);
    run_op("test_div_signed", muldiv_pkg::FN_DIV, -32'sd100, -32'sd7, 0);
    run_op("test_div_signed", muldiv_pkg::FN_DIV, 32'h7fff_ffff, 32'd3, 0);
    run_op("test_div_signed", muldiv_pkg::FN_DIV, 32'h8000_0000, 32'd3, 0);
    // divisor larger than dividend
    run_op("test_div_signed", muldiv_pkg::FN_DIV, 32'd7, 32'd100, 0);
  endtask

  task automatic test_div_unsigned();
    run_op("test_div_unsigned", muldiv_pkg::FN_DIVU, 32'hffff_ffff, 32'd3, 0);
    run_op("test_div_unsigned", muldiv_pkg::FN_DIVU, 32'h8000_0000, 32'h10, 0);
    run_op("test_div_unsigned", muldiv_pkg::FN_DIVU, 32'h9000_0000, 32'h8000_0001, 0);
    run_op("test_div_unsigned", muldiv_pkg::FN_DIVU, 32'd12345, 32'hffff_fff0, 0);
  endtask

  task automatic test_div_corners();
    run_op("test_div_corners", muldiv_pkg::FN_DIV, 32'd5, 32'd0, 0);
    run_op("test_div_corners", muldiv_pkg::FN_DIV, -32'sd5, 32'd0, 0);
    run_op("test_div_corners", muldiv_pkg::FN_DIVU, 32'hdead_beef, 32'd0, 0);
    run_op("test_div_corners", muldiv_pkg::FN_DIV, 32'h8000_0000, 32'hffff_ffff, 0);
    run_op("test_div_corners", muldiv_pkg::FN_DIVU, 32'h8000_0000, 32'hffff_ffff, 0);
  endtask

  task automatic test_backpressure();
    int stall;
    for (int i = 0; i < BP_OPS; i++) begin
      stall = $unsigned($random(seed)) % (MAX_STALL + 1);
      run_op("test_backpressure", random_fn(), $random(seed), $random(seed), stall);
    end
  endtask

  task automatic test_random_mix();
    for (int i = 0; i < RANDOM_OPS; i++) begin
      run_op("test_random_mix", random_fn(), $random(seed), $random(seed), 0);
    end
  endtask

  //--------------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------------

  initial begin
    seed        = 80410;
    cycle_count = 0;
    clk         = 1'b0;
    reset       = 1'b1;
    req_fn      = muldiv_pkg::FN_MUL;
    req_a       = '0;
    req_b       = '0;
    req_val     = 1'b0;
    resp_rdy    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    test_mul_signed();
    test_div_signed();
    test_div_unsigned();
    test_div_corners();
    test_backpressure();
    test_random_mix();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
